// File: memAlign.f
verilog/memAlignPkg.sv
verilog/splitStage.sv
verilog/translateStage.sv
verilog/laneAlign.sv
verilog/memAlignTop.sv
testbench/memAlignChecker.sv
testbench/memAlignTb.sv

// File: runSim.sh
#!/bin/sh
# build the testbench with Verilator, run it, then look for the pass line in the log
rm -f sim.log
verilator --binary --timing --top-module memAlignTb -f memAlign.f -o memAlignSim \
    || { echo "build failed"; exit 1; }
./obj_dir/memAlignSim > sim.log 2>&1
cat sim.log
grep -q "^Verification passed$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: testbench/memAlignTb.sv
`timescale 1ns/1ns

module memAlignTb import memAlignPkg::*; ();

    localparam int resetCycles = 10;
    localparam int fillCount = 8;
    localparam int randomReqs = 200;
    // aligned 8, unaligned 12, crossing 12, miss 5, protection 5
    localparam int totalReqs = 42 + randomReqs;
    localparam int numTests = 6;
    // about six cycles per test to drain the pipe and close it
    localparam int cycleLimit = resetCycles + fillCount + totalReqs + numTests * 8 + 50;

    logic                  clk;
    logic                  rstN;
    logic                  reqValid;
    memReqT                req;
    logic                  tlbWe;
    logic [tlbIdxBits-1:0] tlbIdx;
    tlbEntryT              tlbEntry;
    logic                  respValid;
    alignRespT             resp;
    logic [127:0]          testName;
    logic                  testEnd;
    int                    pending;
    int                    checks;
    int                    errors;
    int                    cycles;
    integer                seed;

    memAlignTop UUT (.*);

    memAlignChecker uChecker (.*);

    initial clk = 1'b0;

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycleLimit) begin
            $display("timeout after %0d cycles with %0d responses still outstanding",
                cycles, pending);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic stepCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic writeTlb(input int idx, input logic [vpnBits-1:0] vpn,
                            input logic [pfnBits-1:0] pfn, input logic present,
                            input logic writable, input logic uncached);
        tlbWe = 1'b1;
        tlbIdx = tlbIdxBits'(idx);
        tlbEntry = {1'b1, vpn, pfn, present, writable, uncached};
        stepCycle();
        tlbWe = 1'b0;
    endtask

    task automatic sendReq(input logic [31:0] addr, input logic [1:0] size,
                           input logic write, input logic [127:0] data);
        reqValid = 1'b1;
        req.vAddr = addr;
        req.size = size;
        req.write = write;
        req.data = data;
        stepCycle();
        reqValid = 1'b0;
    endtask

    // wait for the pipe to empty, then close the test
    task automatic finishTest();
        while (pending != 0) begin
            stepCycle();
        end
        testEnd = 1'b1;
        stepCycle();
        testEnd = 1'b0;
    endtask

    // byte i holds base + i so every lane move is visible
    function automatic logic [127:0] byteRamp(input logic [7:0] base);
        logic [127:0] r;
        for (int i = 0; i < 16; i++) begin
            r[i*8 +: 8] = base + 8'(i);
        end
        return r;
    endfunction

    initial begin
        int          count;
        int          offset;
        int          pick;
        logic [19:0] page;
        logic [31:0] low;
        seed = 32'h97cc;
        rstN = 1'b0;
        reqValid = 1'b0;
        req = '0;
        tlbWe = 1'b0;
        tlbIdx = '0;
        tlbEntry = '0;
        testName = "reset";
        testEnd = 1'b0;
        repeat (resetCycles) @(posedge clk);
        #1;
        rstN = 1'b1;

        writeTlb(0, 20'h00010, 3'd1, 1'b1, 1'b1, 1'b0);
        writeTlb(1, 20'h00011, 3'd2, 1'b1, 1'b1, 1'b0);
        writeTlb(2, 20'h00020, 3'd3, 1'b1, 1'b1, 1'b0);
        writeTlb(3, 20'h00030, 3'd4, 1'b1, 1'b1, 1'b0);
        // paged out
        writeTlb(4, 20'h00031, 3'd5, 1'b0, 1'b1, 1'b0);
        // read-only
        writeTlb(5, 20'h00040, 3'd6, 1'b1, 1'b0, 1'b0);
        writeTlb(6, 20'h00050, 3'd7, 1'b1, 1'b1, 1'b1);
        // duplicate of entry 0, loses on priority
        writeTlb(7, 20'h00010, 3'd0, 1'b1, 1'b0, 1'b1);

        testName = "aligned";
        for (int s = 0; s < 4; s++) begin
            sendReq(32'h0001_0040, 2'(s), 1'b0, byteRamp(8'h10));
            sendReq(32'h0001_0a80, 2'(s), 1'b1, byteRamp(8'h40));
        end
        finishTest();

        testName = "unaligned";
        for (int s = 0; s < 4; s++) begin
            for (int k = 0; k < 3; k++) begin
                count = 1 << s;
                offset = 1 + k * (15 - count) / 2;
                sendReq(32'h0001_1300 + k * 16 + offset, 2'(s), 1'(k), byteRamp(8'h20));
            end
        end
        finishTest();

        testName = "lineCross";
        for (int off = 9; off < 16; off++) begin
            sendReq(32'h0001_03a0 + off, 2'd3, 1'(off), byteRamp(8'h80));
        end
        for (int off = 13; off < 16; off++) begin
            sendReq(32'h0001_05f0 + off, 2'd2, 1'b1, byteRamp(8'ha0));
        end
        sendReq(32'h0001_077f, 2'd1, 1'b0, byteRamp(8'hc0));
        // second half lands in the next page
        sendReq(32'h0001_0ffc, 2'd3, 1'b1, byteRamp(8'he0));
        finishTest();

        testName = "pageMiss";
        sendReq(32'h0002_0ffc, 2'd3, 1'b0, byteRamp(8'h01));
        sendReq(32'h0002_0ffa, 2'd3, 1'b1, byteRamp(8'h31));
        sendReq(32'h0003_0ffe, 2'd2, 1'b0, byteRamp(8'h51));
        sendReq(32'h0003_0ffe, 2'd2, 1'b1, byteRamp(8'h71));
        sendReq(32'h0009_9100, 2'd2, 1'b0, byteRamp(8'h91));
        finishTest();

        testName = "protection";
        sendReq(32'h0004_0108, 2'd2, 1'b1, byteRamp(8'h05));
        sendReq(32'h0004_0108, 2'd2, 1'b0, byteRamp(8'h25));
        sendReq(32'h0004_010c, 2'd3, 1'b1, byteRamp(8'h45));
        sendReq(32'h0005_0200, 2'd2, 1'b1, byteRamp(8'h65));
        sendReq(32'h0005_0200, 2'd2, 1'b0, byteRamp(8'h85));
        finishTest();

        testName = "random";
        for (int n = 0; n < randomReqs; n++) begin
            pick = $unsigned($random(seed)) % 6;
            case (pick)
                0: page = 20'h00010;
                1: page = 20'h00011;
                2: page = 20'h00040;
                3: page = 20'h00050;
                4: page = 20'h00030;
                default: page = 20'h00099;
            endcase
            low = $random(seed);
            sendReq({page, low[11:0]}, 2'($random(seed)), 1'($random(seed)),
                {$random(seed), $random(seed), $random(seed), $random(seed)});
        end
        finishTest();

        $display("summary: %0d responses checked, %0d errors", checks, errors);
        if (errors == 0 && checks == totalReqs) begin
            $display("Verification passed");
        end else begin
            if (checks != totalReqs) begin
                $display("expected %0d responses but %0d were checked", totalReqs, checks);
            end
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: testbench/memAlignChecker.sv
`timescale 1ns/1ns

module memAlignChecker import memAlignPkg::*; (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  reqValid,
    input  memReqT                req,
    input  logic                  tlbWe,
    input  logic [tlbIdxBits-1:0] tlbIdx,
    input  tlbEntryT              tlbEntry,
    input  logic                  respValid,
    input  alignRespT             resp,
    input  logic [127:0]          testName,
    input  logic                  testEnd,
    output int                    pending,
    output int                    checks,
    output int                    errors
);

    // three registered stages between request and response
    localparam int respLatency = 3;

    tlbEntryT     shadow [tlbEntries];
    alignRespT    expQ [$];
    logic [127:0] nameQ [$];
    int           stampQ [$];
    alignRespT    expResp;
    logic [127:0] expName;
    int           stampAt;
    int           cycleCount;
    int           testChecks;
    int           testErrors;

    // first valid entry with this page number, -1 when none
    function automatic int matchIndex(input logic [vpnBits-1:0] vpn);
        int found;
        found = -1;
        for (int i = 0; i < tlbEntries; i++) begin
            if (found < 0 && shadow[i].valid && shadow[i].vpn == vpn) begin
                found = i;
            end
        end
        return found;
    endfunction

    // expected response, built byte by byte from the request
    function automatic alignRespT expectResp(input memReqT r);
        alignRespT   e;
        int          count;
        int          offset;
        int          lastLane;
        int          lane;
        int          idx0;
        int          idx1;
        logic [31:0] addr1;
        logic        need;
        logic        miss0;
        logic        miss1;
        logic        slotOk;
        tlbEntryT    ent0;
        tlbEntryT    ent1;
        count = 1 << r.size;
        offset = int'(r.vAddr[3:0]);
        lastLane = offset + count - 1;
        need = lastLane >= lineBytes;
        addr1 = {r.vAddr[31:4] + 28'd1, 4'h0};
        idx0 = matchIndex(r.vAddr[31:12]);
        idx1 = matchIndex(addr1[31:12]);
        // an unmatched half looks like an all-zero entry
        ent0 = '0;
        ent1 = '0;
        if (idx0 >= 0) begin
            ent0 = shadow[idx0];
        end
        if (idx1 >= 0) begin
            ent1 = shadow[idx1];
        end
        miss0 = (idx0 < 0) || !ent0.present;
        miss1 = need && ((idx1 < 0) || !ent1.present);
        e = '0;
        e.miss = miss0 || miss1;
        e.protFault = r.write && ((!miss0 && !ent0.writable)
            || (need && !miss1 && !ent1.writable));
        e.uncached = ent0.uncached || (need && ent1.uncached);
        slotOk = !e.miss && !e.protFault;
        e.slot0.valid = slotOk;
        e.slot1.valid = slotOk && need;
        e.slot0.lineAddr = {ent0.pfn, r.vAddr[11:4]};
        e.slot1.lineAddr = {ent1.pfn, addr1[11:4]};
        e.slot0.write = r.write;
        e.slot1.write = r.write;
        for (int k = 0; k < lineBytes; k++) begin
            e.slot0.mask[k] = (k >= offset) && (k <= lastLane);
            e.slot1.mask[k] = need && (k <= lastLane - lineBytes);
        end
        // bytes past lane 15 wrap into the next line
        for (int i = 0; i < lineBytes; i++) begin
            lane = offset + i;
            if (lane < lineBytes) begin
                e.slot0.data[lane*8 +: 8] = r.data[i*8 +: 8];
            end else begin
                e.slot1.data[(lane-lineBytes)*8 +: 8] = r.data[i*8 +: 8];
            end
        end
        return e;
    endfunction

    always @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < tlbEntries; i++) begin
                shadow[i] = '0;
            end
            expQ.delete();
            nameQ.delete();
            stampQ.delete();
            cycleCount = 0;
            checks = 0;
            errors = 0;
            testChecks = 0;
            testErrors = 0;
        end else begin
            cycleCount++;
            // a fill is seen by requests sampled on this same edge
            if (tlbWe) begin
                shadow[tlbIdx] = tlbEntry;
            end
            if (reqValid) begin
                expQ.push_back(expectResp(req));
                nameQ.push_back(testName);
                stampQ.push_back(cycleCount);
            end
            if (respValid) begin
                if (expQ.size() == 0) begin
                    $display("%0s: response arrived with no request outstanding", testName);
                    errors++;
                    testErrors++;
                end else begin
                    expResp = expQ.pop_front();
                    expName = nameQ.pop_front();
                    stampAt = stampQ.pop_front();
                    checks++;
                    testChecks++;
                    if (resp !== expResp) begin
                        $display("ERR %0s: expected %h actual %h", expName, expResp, resp);
                        errors++;
                        testErrors++;
                    end
                    // edges from request sample to response sample
                    if (cycleCount - stampAt != respLatency) begin
                        $display("ERR %0s: expected latency %0d actual %0d",
                            expName, respLatency, cycleCount - stampAt);
                        errors++;
                        testErrors++;
                    end
                end
            end
            if (testEnd) begin
                $display("test %0s: %0d responses checked, %0d errors",
                    testName, testChecks, testErrors);
                testChecks = 0;
                testErrors = 0;
            end
        end
        pending = expQ.size();
    end

endmodule

// File: verilog/memAlignTop.sv
`timescale 1ns/1ns

module memAlignTop import memAlignPkg::*; (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  reqValid,
    input  memReqT                req,
    input  logic                  tlbWe,
    input  logic [tlbIdxBits-1:0] tlbIdx,
    input  tlbEntryT              tlbEntry,
    output logic                  respValid,
    output alignRespT             resp
);

    // stage to stage
    logic     splitValid;
    splitReqT split;
    logic     xlatValid;
    xlatReqT  xlat;

    // line-cross detection
    splitStage uSplit (
        .clk        (clk),
        .rstN       (rstN),
        .reqValid   (reqValid),
        .req        (req),
        .splitValid (splitValid),
        .split      (split)
    );

    // TLB lookup for both halves
    translateStage uTranslate (
        .clk        (clk),
        .rstN       (rstN),
        .splitValid (splitValid),
        .split      (split),
        .tlbWe      (tlbWe),
        .tlbIdx     (tlbIdx),
        .tlbEntry   (tlbEntry),
        .xlatValid  (xlatValid),
        .xlat       (xlat)
    );

    // masks and data lanes
    laneAlign uAlign (
        .clk        (clk),
        .rstN       (rstN),
        .xlatValid  (xlatValid),
        .xlat       (xlat),
        .respValid  (respValid),
        .resp       (resp)
    );

endmodule

// File: verilog/laneAlign.sv
`timescale 1ns/1ns

module laneAlign import memAlignPkg::*; (
    input  logic      clk,
    input  logic      rstN,
    input  logic      xlatValid,
    input  xlatReqT   xlat,
    output logic      respValid,
    output alignRespT resp
);

    int                      lastLane;
    logic [3:0]              offset;
    logic [4:0]              backShift;
    logic [lineBytes-1:0]    mask0;
    logic [lineBytes-1:0]    mask1;
    logic [lineBytes*8-1:0]  data0;
    logic [lineBytes*8-1:0]  data1;
    logic                    slotOk;
    alignRespT               respNext;

    // bytes first..last set, lanes outside the line simply drop off
    function automatic logic [lineBytes-1:0] rangeMask(input int first, input int last);
        logic [lineBytes-1:0] m;
        m = '0;
        for (int k = 0; k < lineBytes; k++) begin
            m[k] = (k >= first) && (k <= last);
        end
        return m;
    endfunction

    assign offset = xlat.split.offset;

    // last byte lane, may run past 15 into the next line
    assign lastLane = int'(offset) + int'(xlat.split.byteCount) - 1;

    assign mask0 = rangeMask(int'(offset), lastLane);

    // second line starts at lane 0
    assign mask1 = xlat.split.needSecond ? rangeMask(0, lastLane - lineBytes) : '0;

    // request byte i lands on lane offset + i
    assign data0 = xlat.split.data << {offset, 3'b000};

    // bytes that fell off the first line, back to lane 0
    assign backShift = 5'(lineBytes) - {1'b0, offset};
    assign data1 = xlat.split.data >> {backShift, 3'b000};

    assign slotOk = !xlat.miss && !xlat.protFault;

    always_comb begin
        respNext.slot0.valid = xlatValid && slotOk;
        respNext.slot0.lineAddr = xlat.lineAddr0;
        respNext.slot0.mask = mask0;
        respNext.slot0.data = data0;
        respNext.slot0.write = xlat.split.write;

        respNext.slot1.valid = xlatValid && slotOk && xlat.split.needSecond;
        respNext.slot1.lineAddr = xlat.lineAddr1;
        respNext.slot1.mask = mask1;
        respNext.slot1.data = data1;
        respNext.slot1.write = xlat.split.write;

        respNext.miss = xlat.miss;
        respNext.protFault = xlat.protFault;
        respNext.uncached = xlat.uncached;
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            respValid <= 1'b0;
        end else begin
            respValid <= xlatValid;
        end
    end

    always_ff @(posedge clk) begin
        if (xlatValid) begin
            resp <= respNext;
        end
    end

endmodule

// File: verilog/translateStage.sv
`timescale 1ns/1ns

module translateStage import memAlignPkg::*; (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  splitValid,
    input  splitReqT              split,
    input  logic                  tlbWe,
    input  logic [tlbIdxBits-1:0] tlbIdx,
    input  tlbEntryT              tlbEntry,
    output logic                  xlatValid,
    output xlatReqT               xlat
);

    tlbEntryT              tlbTable [tlbEntries];

    logic                  hit0;
    logic                  hit1;
    logic [tlbIdxBits-1:0] idx0;
    logic [tlbIdxBits-1:0] idx1;
    tlbEntryT              entry0;
    tlbEntryT              entry1;
    logic                  miss0;
    logic                  miss1;
    logic                  fault0;
    logic                  fault1;
    logic [pfnBits-1:0]    pfn0;
    logic [pfnBits-1:0]    pfn1;
    xlatReqT               xlatNext;

    // fill port, all entries start out invalid
    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < tlbEntries; i++) begin
                tlbTable[i] <= '0;
            end
        end else if (tlbWe) begin
            tlbTable[tlbIdx] <= tlbEntry;
        end
    end

    // associative search, returns {hit, index}
    // scanning downward lets the lowest matching index win
    function automatic logic [tlbIdxBits:0] findEntry(input logic [vpnBits-1:0] vpn);
        logic [tlbIdxBits:0] result;
        result = '0;
        for (int i = tlbEntries - 1; i >= 0; i--) begin
            if (tlbTable[i].valid && tlbTable[i].vpn == vpn) begin
                result = {1'b1, tlbIdxBits'(i)};
            end
        end
        return result;
    endfunction

    assign {hit0, idx0} = findEntry(split.vAddr0[31:32-vpnBits]);
    assign {hit1, idx1} = findEntry(split.vAddr1[31:32-vpnBits]);

    assign entry0 = tlbTable[idx0];
    assign entry1 = tlbTable[idx1];

    // second half only matters for a line-crossing access
    assign miss0 = !hit0 || !entry0.present;
    assign miss1 = split.needSecond && (!hit1 || !entry1.present);

    // no fault reported on a half that already missed
    assign fault0 = split.write && !miss0 && !entry0.writable;
    assign fault1 = split.write && split.needSecond && !miss1 && !entry1.writable;

    // a missing half reads as frame 0
    assign pfn0 = hit0 ? entry0.pfn : '0;
    assign pfn1 = hit1 ? entry1.pfn : '0;

    always_comb begin
        xlatNext.split = split;
        xlatNext.lineAddr0 = {pfn0, split.vAddr0[11:4]};
        xlatNext.lineAddr1 = {pfn1, split.vAddr1[11:4]};
        xlatNext.miss = miss0 || miss1;
        xlatNext.protFault = fault0 || fault1;
        xlatNext.uncached = (hit0 && entry0.uncached)
            || (split.needSecond && hit1 && entry1.uncached);
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            xlatValid <= 1'b0;
        end else begin
            xlatValid <= splitValid;
        end
    end

    always_ff @(posedge clk) begin
        if (splitValid) begin
            xlat <= xlatNext;
        end
    end

endmodule

// File: verilog/splitStage.sv
`timescale 1ns/1ns

module splitStage import memAlignPkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  logic     reqValid,
    input  memReqT   req,
    output logic     splitValid,
    output splitReqT split
);

    logic [3:0]  byteCount;
    logic [3:0]  offset;
    logic [4:0]  laneEnd;
    logic [31:0] nextLine;
    splitReqT    splitNext;

    // size code to number of bytes
    always_comb begin
        case (req.size)
            2'd0: begin
                byteCount = 4'd1;
            end
            2'd1: begin
                byteCount = 4'd2;
            end
            2'd2: begin
                byteCount = 4'd4;
            end
            default: begin
                byteCount = 4'd8;
            end
        endcase
    end

    assign offset = req.vAddr[3:0];

    // one past the last byte, counted from the line start
    assign laneEnd = {1'b0, offset} + {1'b0, byteCount};

    // address one line further on
    assign nextLine = req.vAddr + 32'(lineBytes);

    always_comb begin
        splitNext.vAddr0 = req.vAddr;
        splitNext.vAddr1 = {nextLine[31:4], 4'b0000};
        splitNext.offset = offset;
        splitNext.byteCount = byteCount;
        // access spills into the following line
        splitNext.needSecond = laneEnd > 5'(lineBytes);
        splitNext.data = req.data;
        splitNext.write = req.write;
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            splitValid <= 1'b0;
        end else begin
            splitValid <= reqValid;
        end
    end

    // payload follows the strobe
    always_ff @(posedge clk) begin
        if (reqValid) begin
            split <= splitNext;
        end
    end

endmodule

// File: verilog/memAlignPkg.sv
package memAlignPkg;

    // cache line geometry
    localparam int lineBytes = 16;

    // TLB shape
    localparam int tlbEntries = 8;
    localparam int tlbIdxBits = 3;
    localparam int vpnBits = 20;
    localparam int pfnBits = 3;

    // frame number followed by vaddr[11:4]
    localparam int lineAddrBits = 11;

    // incoming load/store request
    typedef struct packed {
        logic [31:0]              vAddr;
        logic [lineBytes*8-1:0]   data;
        logic [1:0]               size;
        logic                     write;
    } memReqT;

    // one TLB entry as written through the fill port
    typedef struct packed {
        logic                     valid;
        logic [vpnBits-1:0]       vpn;
        logic [pfnBits-1:0]       pfn;
        logic                     present;
        logic                     writable;
        logic                     uncached;
    } tlbEntryT;

    // split stage result, vAddr1 is the line-aligned next line
    typedef struct packed {
        logic [31:0]              vAddr0;
        logic [31:0]              vAddr1;
        logic [3:0]               offset;
        logic [3:0]               byteCount;
        logic                     needSecond;
        logic [lineBytes*8-1:0]   data;
        logic                     write;
    } splitReqT;

    // translate stage result
    typedef struct packed {
        splitReqT                 split;
        logic [lineAddrBits-1:0]  lineAddr0;
        logic [lineAddrBits-1:0]  lineAddr1;
        logic                     miss;
        logic                     protFault;
        logic                     uncached;
    } xlatReqT;

    // one line access slot
    typedef struct packed {
        logic                     valid;
        logic [lineAddrBits-1:0]  lineAddr;
        logic [lineBytes-1:0]     mask;
        logic [lineBytes*8-1:0]   data;
        logic                     write;
    } lineAccessT;

    // full response
    typedef struct packed {
        lineAccessT               slot0;
        lineAccessT               slot1;
        logic                     miss;
        logic                     protFault;
        logic                     uncached;
    } alignRespT;

endpackage
